//--- verilog.f
design/cpuPkg.sv
design/controlUnit.sv
design/regFile.sv
design/alu.sv
design/cpuCore.sv
test/memModel.sv
test/tbCpu.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - design/cpuPkg.sv
  - design/controlUnit.sv
  - design/regFile.sv
  - design/alu.sv
  - design/cpuCore.sv
  - target: test
    files:
      - test/memModel.sv
      - test/tbCpu.sv

//--- test/tbCpu.sv
`timescale 1ns/1ps
`default_nettype none

module tbCpu import cpuPkg::*; ();

    logic clk;
    logic rstN;
    logic readM1;
    logic readM2;
    logic writeM2;
    logic isHalted;
    wordT address1;
    wordT data1;
    wordT address2;
    wordT writeData2;
    wordT data2;
    wordT numInst;
    wordT outputPort;

    integer seed = 32'hf4e2_8cd4;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     testErrors;
    wordT   loadAddr;
    wordT   outLog [$];   // values seen on outputPort
    wordT   expOut [$];
    wordT   accessLog [$];   // address2 of every load and store
    wordT   expAccess [$];
    logic   wwdPending;

    cpuCore DUT (.*);
    memModel mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // a WWD retires on the next edge, so its value is read one cycle later
    always @(negedge clk) begin
        if (wwdPending) begin
            outLog.push_back(outputPort);
        end
        wwdPending = readM1 && data1[15:12] == opRType && data1[5:0] == funcWwd;
    end

    // full 16-bit data address of each load and store
    always @(negedge clk) begin
        if (readM2 || writeM2) begin
            accessLog.push_back(address2);
        end
    end

    function automatic wordT rType(funcT f, regIdxT rs, regIdxT rt, regIdxT rd);
        return {opRType, rs, rt, rd, f};
    endfunction

    function automatic wordT iType(opcodeT op, regIdxT rs, regIdxT rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT sext(logic [7:0] b);
        return {{8{b[7]}}, b};
    endfunction

    function automatic wordT wwd(regIdxT rs);
        return rType(funcWwd, rs, 2'd0, 2'd0);
    endfunction

    task automatic emit(wordT word);
        mem.loadWord(loadAddr, word);
        loadAddr = loadAddr + 16'd1;
    endtask

    // LHI then ORI builds any 16-bit constant
    task automatic loadConst(regIdxT rt, wordT value);
        emit(iType(opLhi, 2'd0, rt, value[15:8]));
        emit(iType(opOri, rt, rt, value[7:0]));
    endtask

    task automatic checkValue(string name, wordT expected, wordT actual);
        checks++;
        assert (actual === expected) else begin
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkTrue(logic cond, string what);
        checks++;
        assert (cond) else begin
            $display("error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic startTest();
        @(posedge clk);
        #1 rstN = 1'b0;
        mem.clearAll();
        outLog.delete();
        expOut.delete();
        accessLog.delete();
        expAccess.delete();
        loadAddr = '0;
        testErrors = errors;
    endtask

    task automatic runProgram(string name, wordT expCount);
        int cycles;
        repeat (8) @(posedge clk);
        #1 rstN = 1'b1;
        cycles = 0;
        while (!isHalted && cycles < 300) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        checkTrue(isHalted, $sformatf("%s never halted within 300 cycles", name));
        checkValue("numInst", expCount, numInst);
        repeat (20) begin   // halted core must stay frozen
            @(posedge clk);
            #1;
            checkValue("numInst", expCount, numInst);
            checkTrue(!readM1 && !readM2 && !writeM2, "memory strobe high while halted");
        end
        checkTrue(outLog.size() == expOut.size(), $sformatf("%s saw %0d WWD values, expected %0d",
            name, outLog.size(), expOut.size()));
        foreach (expOut[i]) begin
            if (i < outLog.size()) begin
                checkValue($sformatf("outputPort[%0d]", i), expOut[i], outLog[i]);
            end
        end
        checkTrue(accessLog.size() == expAccess.size(),
            $sformatf("%s saw %0d data accesses, expected %0d",
            name, accessLog.size(), expAccess.size()));
        foreach (expAccess[i]) begin
            if (i < accessLog.size()) begin
                checkValue($sformatf("address2[%0d]", i), expAccess[i], accessLog[i]);
            end
        end
    endtask

    task automatic reportTest(string name);
        tests++;
        $display("%s: %0d errors", name, errors - testErrors);
    endtask

    task automatic testRType();
        wordT a;
        wordT b;
        wordT expected;
        int   run;
        int   k;
        for (run = 0; run < 3; run++) begin
            a = $random(seed);
            b = $random(seed);
            startTest();
            loadConst(2'd0, a);
            loadConst(2'd1, b);
            for (k = 0; k < 8; k++) begin
                emit(rType(funcT'(k), 2'd0, 2'd1, 2'd2));
                emit(wwd(2'd2));
                case (funcT'(k))
                    funcAdd: expected = a + b;
                    funcSub: expected = a - b;
                    funcAnd: expected = a & b;
                    funcOrr: expected = a | b;
                    funcNot: expected = ~a;
                    funcTcp: expected = 16'd0 - a;
                    funcShl: expected = a << 1;
                    default: expected = $signed(a) >>> 1;   // SHR keeps the sign
                endcase
                expOut.push_back(expected);
            end
            emit(rType(funcHlt, 2'd0, 2'd0, 2'd0));
            runProgram($sformatf("rtype run %0d", run), 16'd21);
            reportTest($sformatf("rtype run %0d", run));
        end
    endtask

    task automatic testImmediates();
        wordT base;
        base = 16'h1234;
        startTest();
        loadConst(2'd0, base);
        emit(wwd(2'd0));
        expOut.push_back(base);
        emit(iType(opOri, 2'd0, 2'd1, 8'h9c));   // high bit set, must not extend
        emit(wwd(2'd1));
        expOut.push_back(base | {8'h00, 8'h9c});
        emit(iType(opAdi, 2'd0, 2'd2, 8'hf0));
        emit(wwd(2'd2));
        expOut.push_back(base + sext(8'hf0));
        emit(iType(opAdi, 2'd2, 2'd3, 8'h80));
        emit(wwd(2'd3));
        expOut.push_back(base + sext(8'hf0) + sext(8'h80));
        emit(iType(opLhi, 2'd0, 2'd1, 8'ha5));
        emit(wwd(2'd1));
        expOut.push_back({8'ha5, 8'h00});
        emit(rType(funcHlt, 2'd0, 2'd0, 2'd0));
        runProgram("immediates", 16'd12);
        reportTest("immediates");
    endtask

    task automatic testMemory();
        wordT d;
        wordT e;
        wordT base;
        d = $random(seed);
        e = $random(seed);
        base = 16'h0090;
        startTest();
        emit(iType(opOri, 2'd0, 2'd0, base[7:0]));
        loadConst(2'd1, d);
        emit(iType(opSwd, 2'd0, 2'd1, 8'hfc));   // negative offset
        emit(iType(opLwd, 2'd0, 2'd2, 8'hfc));
        emit(wwd(2'd2));
        expOut.push_back(d);
        expAccess.push_back(base + sext(8'hfc));
        expAccess.push_back(base + sext(8'hfc));
        loadConst(2'd1, e);
        emit(iType(opSwd, 2'd0, 2'd1, 8'h05));
        emit(iType(opLwd, 2'd0, 2'd3, 8'h05));
        emit(wwd(2'd3));
        expOut.push_back(e);
        expAccess.push_back(base + sext(8'h05));
        expAccess.push_back(base + sext(8'h05));
        emit(rType(funcHlt, 2'd0, 2'd0, 2'd0));
        runProgram("memory", 16'd12);
        checkValue("mem word at r0-4", d, mem.peekWord(base + sext(8'hfc)));
        checkValue("mem word at r0+5", e, mem.peekWord(base + sext(8'h05)));
        reportTest("memory");
    endtask

    task automatic testBranches();
        startTest();
        emit(iType(opOri, 2'd0, 2'd0, 8'd5));
        emit(iType(opOri, 2'd1, 2'd1, 8'd5));
        emit(iType(opAdi, 2'd3, 2'd3, 8'hfd));   // r3 = -3
        emit(iType(opBne, 2'd0, 2'd1, 8'd1));    // not taken
        emit(wwd(2'd0));
        expOut.push_back(16'd5);
        emit(iType(opBeq, 2'd0, 2'd1, 8'd1));    // taken
        emit(wwd(2'd3));
        emit(iType(opBgz, 2'd0, 2'd0, 8'd1));    // taken
        emit(wwd(2'd3));
        emit(iType(opBlz, 2'd0, 2'd0, 8'd1));    // not taken
        emit(wwd(2'd1));
        expOut.push_back(16'd5);
        emit(iType(opBlz, 2'd3, 2'd0, 8'd1));    // taken
        emit(wwd(2'd0));
        emit(iType(opBgz, 2'd3, 2'd0, 8'd1));    // not taken
        emit(wwd(2'd3));
        expOut.push_back(sext(8'hfd));
        emit(iType(opBne, 2'd0, 2'd3, 8'd1));    // taken
        emit(wwd(2'd0));
        emit(iType(opBeq, 2'd0, 2'd3, 8'd1));    // not taken
        emit(wwd(2'd0));
        expOut.push_back(16'd5);
        emit({opJmp, 12'd22});                   // at 19
        emit(wwd(2'd0));
        emit(wwd(2'd0));
        emit({opJal, 12'd30});                   // at 22
        expOut.push_back(16'd22 + 16'd1);
        emit(iType(opAdi, 2'd1, 2'd1, 8'h23));   // r1 = 40
        emit(rType(funcJrl, 2'd1, 2'd0, 2'd0));  // at 24
        expOut.push_back(16'd24 + 16'd1);
        loadAddr = 16'd30;
        emit(wwd(2'd2));
        emit(rType(funcJpr, 2'd2, 2'd0, 2'd0));  // back to 23
        loadAddr = 16'd5 + sext(8'h23);
        emit(wwd(2'd2));
        emit(rType(funcHlt, 2'd0, 2'd0, 2'd0));
        runProgram("branches", 16'd23);
        reportTest("branches");
    endtask

    initial begin
        rstN = 1'b0;
        wwdPending = 1'b0;
        loadAddr = '0;
        testRType();
        testImmediates();
        testMemory();
        testBranches();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/memModel.sv
`timescale 1ns/1ps
`default_nettype none

module memModel import cpuPkg::*; (
    input  logic clk,
    input  logic readM1,
    input  wordT address1,
    output wordT data1,
    input  logic readM2,
    input  logic writeM2,
    input  wordT address2,
    input  wordT writeData2,
    output wordT data2
);

    wordT words [256];

    // idle ports return zero, which decodes as BNE r0, r0 and is never taken
    assign data1 = readM1 ? words[address1[7:0]] : '0;
    assign data2 = readM2 ? words[address2[7:0]] : '0;

    always @(posedge clk) begin
        if (writeM2) begin
            words[address2[7:0]] <= writeData2;
        end
    end

    // opcode 4'hb is unused, so a stray fetch runs as a no-op
    task automatic clearAll();
        for (int i = 0; i < 256; i++) begin
            words[i] = 16'hb000 | 16'(i);   // low byte is the address
        end
    endtask

    task automatic loadWord(wordT addr, wordT value);
        words[addr[7:0]] = value;
    endtask

    function automatic wordT peekWord(wordT addr);
        return words[addr[7:0]];
    endfunction

    initial begin
        clearAll();
    end

endmodule

`default_nettype wire

//--- design/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore import cpuPkg::*; (
    input  logic clk,
    input  logic rstN,
    // instruction port
    output logic readM1,
    output wordT address1,
    input  wordT data1,
    // data port
    output logic readM2,
    output logic writeM2,
    output wordT address2,
    output wordT writeData2,
    input  wordT data2,
    // status
    output wordT numInst,
    output wordT outputPort,
    output logic isHalted
);

    wordT   pc;
    wordT   pcPlus1;
    wordT   nextPc;
    ctrlT   ctrl;
    fieldsT fields;
    wordT   imm;
    wordT   rsData;
    wordT   rtData;
    wordT   aluB;
    wordT   aluResult;
    logic   branchTaken;
    wordT   writeBack;
    logic   running;

    assign running = rstN && !isHalted;

    controlUnit decoder (
        .instr  (data1),
        .ctrl   (ctrl),
        .fields (fields),
        .imm    (imm)
    );

    regFile regs (
        .clk       (clk),
        .rstN      (rstN),
        .rs        (fields.rs),
        .rt        (fields.rt),
        .rd        (fields.rd),
        .writeData (writeBack),
        .writeEn   (ctrl.regWrite && !isHalted),
        .readData1 (rsData),
        .readData2 (rtData)
    );

    assign aluB = ctrl.aluSrcImm ? imm : rtData;

    alu execUnit (
        .operandA    (rsData),
        .operandB    (aluB),
        .aluOp       (ctrl.aluOp),
        .branchType  (ctrl.branchType),
        .result      (aluResult),
        .branchTaken (branchTaken)
    );

    // fetch
    assign readM1   = running;
    assign address1 = pc;
    assign pcPlus1  = pc + 16'd1;

    // data memory, address from the alu
    assign readM2     = running && ctrl.memRead;
    assign writeM2    = running && ctrl.memWrite;
    assign address2   = aluResult;
    assign writeData2 = rtData;

    always_comb begin
        if (ctrl.linkWrite) begin
            writeBack = pcPlus1;   // JAL / JRL return address
        end else if (ctrl.memToReg) begin
            writeBack = data2;
        end else begin
            writeBack = aluResult;
        end
    end

    always_comb begin
        if (ctrl.isHalt) begin
            nextPc = pc;
        end else if (ctrl.jumpReg) begin
            nextPc = rsData;
        end else if (ctrl.jumpAbs) begin
            nextPc = {pc[15:12], data1[11:0]};
        end else if (branchTaken) begin
            nextPc = pcPlus1 + imm;
        end else begin
            nextPc = pcPlus1;
        end
    end

    // one instruction retires per edge until HLT
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc         <= '0;
            numInst    <= '0;
            outputPort <= '0;
            isHalted   <= 1'b0;
        end else if (!isHalted) begin
            pc      <= nextPc;
            numInst <= numInst + 16'd1;   // HLT counts too
            if (ctrl.isWwd) begin
                outputPort <= rsData;
            end
            if (ctrl.isHalt) begin
                isHalted <= 1'b1;
            end
        end
    end

    noReadWriteClash: assert property (@(posedge clk) disable iff (!rstN)
        !(readM2 && writeM2))
        else $error("cpuCore: readM2 and writeM2 both high at %0t", $time);

    pcFrozenWhenHalted: assert property (@(posedge clk) disable iff (!rstN)
        isHalted |=> $stable(pc))
        else $error("cpuCore: pc moved while halted at %0t", $time);

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpuPkg::*; (
    input  wordT   operandA,
    input  wordT   operandB,
    input  aluOpT  aluOp,
    input  branchT branchType,
    output wordT   result,
    output logic   branchTaken
);

    logic signed [15:0] signedA;

    assign signedA = operandA;

    always_comb begin
        case (aluOp)
            aluAdd:  result = operandA + operandB;
            aluSub:  result = operandA - operandB;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluNot:  result = ~operandA;
            aluTcp:  result = ~operandA + 16'd1;
            aluShl:  result = {operandA[14:0], 1'b0};
            aluShr:  result = {operandA[15], operandA[15:1]};   // arithmetic, keeps sign
            aluLhi:  result = {operandB[7:0], 8'h00};
            default: result = '0;
        endcase
    end

    // branch conditions compare rs with rt, or rs with zero
    always_comb begin
        case (branchType)
            brNe:    branchTaken = (operandA != operandB);
            brEq:    branchTaken = (operandA == operandB);
            brGz:    branchTaken = (signedA > 0);
            brLz:    branchTaken = (signedA < 0);
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  regIdxT rs,
    input  regIdxT rt,
    input  regIdxT rd,
    input  wordT   writeData,
    input  logic   writeEn,
    output wordT   readData1,
    output wordT   readData2
);

    wordT regs [4];

    // read ports see the old value during a write cycle
    assign readData1 = regs[rs];
    assign readData2 = regs[rt];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[rd] <= writeData;
        end
    end

    // a stray X here would corrupt a register silently
    writeEnKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(writeEn))
        else $error("regFile: writeEn unknown at %0t", $time);

endmodule

`default_nettype wire

//--- design/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit import cpuPkg::*; (
    input  wordT   instr,
    output ctrlT   ctrl,
    output fieldsT fields,
    output wordT   imm
);

    opcodeT opcode;
    funcT   func;
    regIdxT dest;

    assign opcode = opcodeT'(instr[15:12]);
    assign func   = funcT'(instr[5:0]);

    assign fields.rs = instr[11:10];
    assign fields.rt = instr[9:8];
    assign fields.rd = dest;

    // immediate forms
    always_comb begin
        case (opcode)
            opOri, opLhi: imm = {8'h00, instr[7:0]};          // zero-extended / raw byte
            default:      imm = {{8{instr[7]}}, instr[7:0]};  // sign-extended
        endcase
    end

    always_comb begin
        ctrl            = '0;
        ctrl.aluOp      = aluAdd;
        ctrl.branchType = brNone;
        dest            = instr[9:8];   // rt for immediates and loads
        case (opcode)
            opBne: ctrl.branchType = brNe;
            opBeq: ctrl.branchType = brEq;
            opBgz: ctrl.branchType = brGz;
            opBlz: ctrl.branchType = brLz;
            opAdi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opOri: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluOr;
            end
            opLhi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluLhi;
            end
            opLwd: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;   // address is rs + imm
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
            end
            opSwd: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
            end
            opJmp: ctrl.jumpAbs = 1'b1;
            opJal: begin
                ctrl.jumpAbs   = 1'b1;
                ctrl.linkWrite = 1'b1;
                ctrl.regWrite  = 1'b1;
                dest           = 2'd2;
            end
            opRType: begin
                dest = instr[7:6];
                case (func)
                    funcAdd, funcSub, funcAnd, funcOrr,
                    funcNot, funcTcp, funcShl, funcShr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluOpT'({1'b0, instr[2:0]});
                    end
                    funcJpr: ctrl.jumpReg = 1'b1;
                    funcJrl: begin
                        ctrl.jumpReg   = 1'b1;
                        ctrl.linkWrite = 1'b1;
                        ctrl.regWrite  = 1'b1;
                        dest           = 2'd2;
                    end
                    funcWwd: ctrl.isWwd  = 1'b1;
                    funcHlt: ctrl.isHalt = 1'b1;
                    default: ;   // unknown func, no-op
                endcase
            end
            default: ;   // unknown opcode, no-op
        endcase
    end

endmodule

`default_nettype wire

//--- design/cpuPkg.sv
`default_nettype none

package cpuPkg;

    typedef logic [15:0] wordT;
    typedef logic [1:0]  regIdxT;

    // opcode field, bits 15..12
    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opBgz   = 4'd2,
        opBlz   = 4'd3,
        opAdi   = 4'd4,
        opOri   = 4'd5,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opJal   = 4'd10,
        opRType = 4'd15
    } opcodeT;

    // function field of R-type words, bits 5..0
    typedef enum logic [5:0] {
        funcAdd = 6'd0,
        funcSub = 6'd1,
        funcAnd = 6'd2,
        funcOrr = 6'd3,
        funcNot = 6'd4,
        funcTcp = 6'd5,
        funcShl = 6'd6,
        funcShr = 6'd7,
        funcJpr = 6'd25,
        funcJrl = 6'd26,
        funcWwd = 6'd28,
        funcHlt = 6'd29
    } funcT;

    // first eight codes line up with funcAdd..funcShr
    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluNot = 4'd4,
        aluTcp = 4'd5,
        aluShl = 4'd6,
        aluShr = 4'd7,
        aluLhi = 4'd8
    } aluOpT;

    typedef enum logic [2:0] {
        brNone = 3'd0,
        brNe   = 3'd1,
        brEq   = 3'd2,
        brGz   = 3'd3,
        brLz   = 3'd4
    } branchT;

    typedef struct packed {
        logic   regWrite;
        logic   aluSrcImm;   // operand B from imm instead of rt
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   linkWrite;   // PC+1 goes to r2
        logic   jumpAbs;
        logic   jumpReg;
        logic   isWwd;
        logic   isHalt;
        aluOpT  aluOp;
        branchT branchType;
    } ctrlT;

    typedef struct packed {
        regIdxT rs;
        regIdxT rt;
        regIdxT rd;   // resolved destination
    } fieldsT;

endpackage

`default_nettype wire
